// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= bicubic_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== include/bicubic_config.svh ====
`ifndef BICUBIC_CONFIG_SVH
`define BICUBIC_CONFIG_SVH

// Unsigned input and output pixel
`define BICUBIC_PIXEL_W 8

// Zero-extended pixel (9 bits) times a signed 12-bit weight
`define BICUBIC_PROD_W 21

// Four products plus the rounding offset, with headroom
`define BICUBIC_SUM_W 23

// Weights are in units of 1/2048
`define BICUBIC_FRAC_BITS 11

// Register stages in each weight multiplier, 0 to 2
`define BICUBIC_MULT_STAGES 2

`endif

// ==== project.f ====
+incdir+include
src/bicubic_pkg.sv
src/bicubic_tap_if.sv
src/bicubic_weight_mult.sv
src/bicubic_tap_mult.sv
src/bicubic_tap_sum.sv
src/bicubic_interp_top.sv
sim/bicubic_assertions.sv
sim/bicubic_tb.sv

// ==== sim/bicubic_assertions.sv ====
`timescale 1ns/1ps

module bicubic_assertions (
    input logic       clk,
    input logic       rst_n,
    input logic       en,
    input logic       in_valid,
    input logic       out_valid,
    input logic [7:0] out_pixel
);

    // Synchronous reset clears the output on the next edge
    a_reset_clears: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high after a reset edge");

    a_freeze: assert property (@(posedge clk)
        ($past(rst_n) && !$past(en)) |->
            (out_valid == $past(out_valid) && out_pixel == $past(out_pixel)))
        else $error("Output changed across an edge with en low");

    // Default build has two multiplier stages plus the sum register
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n, 3) && $past(en && in_valid, 3) &&
         $past(en, 2) && $past(en, 1)) |-> out_valid)
        else $error("Sample not out after three enabled edges");

endmodule

bind bicubic_interp_top bicubic_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_pixel (out_pixel)
);

// ==== sim/bicubic_cases.txt ====
# name pixel0 pixel1 pixel2 pixel3 phase expected
# Pixels and results in decimal, phase 0 to 3
flat_0_p0 0 0 0 0 0 0
flat_255_p1 255 255 255 255 1 255
flat_128_p2 128 128 128 128 2 128
flat_77_p3 77 77 77 77 3 77
ramp_up_p0 10 20 30 40 0 22
ramp_up_p1 10 20 30 40 1 24
ramp_up_p2 10 20 30 40 2 26
ramp_up_p3 10 20 30 40 3 28
ramp_dn_p0 40 30 20 10 0 28
ramp_dn_p1 40 30 20 10 1 26
step_up_p1 0 0 200 200 1 72
step_up_p2 0 0 200 200 2 128
step_up_p3 0 0 200 200 3 179
step_dn_p0 200 200 0 0 0 179
over_p1 0 255 255 0 1 255
under_p1 255 0 0 255 1 0
edge_p0 0 0 0 100 0 0
peak_p0 0 255 0 0 0 247

// ==== sim/bicubic_tb.sv ====
`timescale 1ns/1ps

module bicubic_tb;

    localparam int    LATENCY   = 3;
    localparam int    MAX_WAIT  = 200;
    localparam string CASE_FILE = "sim/bicubic_cases.txt";

    logic       clk;
    logic       rst_n;
    logic       en;
    logic       in_valid;
    logic [1:0] phase;
    logic [7:0] pixel0;
    logic [7:0] pixel1;
    logic [7:0] pixel2;
    logic [7:0] pixel3;
    logic       out_valid;
    logic [7:0] out_pixel;

    string       case_name[$];
    logic [31:0] case_pixels[$];
    int          case_phase[$];
    int          case_exp[$];

    // Samples in flight, in input order
    string exp_name_q[$];
    int    exp_q[$];
    int    accept_q[$];

    string       drv_name;
    int          drv_exp;
    int          edge_count;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr   = 32'h89b;

    bicubic_interp_top u_bicubic_interp_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .in_valid  (in_valid),
        .phase     (phase),
        .pixel0    (pixel0),
        .pixel1    (pixel1),
        .pixel2    (pixel2),
        .pixel3    (pixel3),
        .out_valid (out_valid),
        .out_pixel (out_pixel)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic random_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    // Roughly three edges in four are enabled when gaps are on
    function automatic logic pick_en(bit gaps);
        logic b0;
        logic b1;
        if (!gaps) begin
            return 1'b1;
        end
        b0 = random_bit();
        b1 = random_bit();
        return b0 | b1;
    endfunction

    // Weighted sum in 1/2048 units, rounded half up and clamped to a pixel
    function automatic int predict(logic [31:0] pix, int ph);
        int w [4];
        int acc;
        int q;
        case (ph)
            0: w = '{-147, 1981, 235, -21};
            1: w = '{-225, 1535, 873, -135};
            2: w = '{-135, 873, 1535, -225};
            default: w = '{-21, 235, 1981, -147};
        endcase
        acc = 1024;
        for (int i = 0; i < 4; i++) begin
            acc += w[i] * int'(pix[8*i +: 8]);
        end
        if (acc < 0) begin
            q = -((-acc + 2047) / 2048);
        end else begin
            q = acc / 2048;
        end
        return (q < 0) ? 0 : ((q > 255) ? 255 : q);
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    n;
        int    p0;
        int    p1;
        int    p2;
        int    p3;
        int    ph;
        int    ex;
        string line;
        string name;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the case file %s", CASE_FILE);
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;
            n = $sscanf(line, "%s %d %d %d %d %d %d", name, p0, p1, p2, p3, ph, ex);
            if (n != 7) begin
                $display("Malformed line in the case file: %s", line);
                errors++;
            end else begin
                case_name.push_back(name);
                case_pixels.push_back({p3[7:0], p2[7:0], p1[7:0], p0[7:0]});
                case_phase.push_back(ph);
                case_exp.push_back(ex);
            end
        end
        $fclose(fd);
    endtask

    // Holds one sample on the inputs until an enabled edge takes it
    task automatic drive_sample(int idx, bit gaps);
        logic [31:0] pix;
        int          waited;
        pix = case_pixels[idx];
        pixel0   <= pix[7:0];
        pixel1   <= pix[15:8];
        pixel2   <= pix[23:16];
        pixel3   <= pix[31:24];
        phase    <= 2'(case_phase[idx]);
        in_valid <= 1'b1;
        en       <= pick_en(gaps);
        drv_name <= case_name[idx];
        drv_exp  <= case_exp[idx];
        waited = 0;
        @(posedge clk);
        while (!en && waited < MAX_WAIT) begin
            en <= pick_en(gaps);
            waited++;
            @(posedge clk);
        end
        if (!en) begin
            $display("Timeout: sample %s was never taken by the DUT", case_name[idx]);
            errors++;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < MAX_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d results never came out of the DUT", exp_q.size());
            errors++;
        end
    endtask

    task automatic stream_cases(bit gaps);
        for (int i = 0; i < case_name.size(); i++) begin
            drive_sample(i, gaps);
        end
        in_valid <= 1'b0;
        en       <= 1'b1;
        wait_drain();
    endtask

    // Every enabled edge retires the output register and may take a sample
    always @(posedge clk) begin : monitor
        string name;
        if (!rst_n) begin
            edge_count = 0;
        end else if (en) begin
            edge_count++;
            if (out_valid && exp_q.size() == 0) begin
                $display("Output valid seen with no sample in flight");
                errors++;
            end else if (out_valid) begin
                name = exp_name_q.pop_front();
                check_value(name, exp_q.pop_front(), out_pixel);
                // The accepting edge counts as the first of the enabled edges
                check_value({name, "_latency"}, LATENCY,
                            edge_count - accept_q.pop_front());
            end
            if (in_valid) begin
                exp_name_q.push_back(drv_name);
                exp_q.push_back(drv_exp);
                accept_q.push_back(edge_count);
            end
        end
    end

    initial begin
        rst_n    = 1'b0;
        en       = 1'b0;
        in_valid = 1'b0;
        phase    = 2'd0;
        pixel0   = 8'd0;
        pixel1   = 8'd0;
        pixel2   = 8'd0;
        pixel3   = 8'd0;
        drv_name = "";
        drv_exp  = 0;
        load_cases();
        if (case_name.size() == 0) begin
            $display("No cases were loaded");
            errors++;
        end
        foreach (case_name[i]) begin
            check_value({case_name[i], "_rule"}, predict(case_pixels[i], case_phase[i]),
                        case_exp[i]);
        end

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        en    <= 1'b1;
        repeat (6) begin
            @(posedge clk);
            check_value("idle_after_reset", 0, out_valid);
        end

        stream_cases(1'b0);
        stream_cases(1'b1);

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== src/bicubic_interp_top.sv ====
`timescale 1ns/1ps
`include "bicubic_config.svh"

module bicubic_interp_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        en,
    input  logic                        in_valid,
    input  logic [1:0]                  phase,
    input  logic [`BICUBIC_PIXEL_W-1:0] pixel0,
    input  logic [`BICUBIC_PIXEL_W-1:0] pixel1,
    input  logic [`BICUBIC_PIXEL_W-1:0] pixel2,
    input  logic [`BICUBIC_PIXEL_W-1:0] pixel3,
    output logic                        out_valid,
    output logic [`BICUBIC_PIXEL_W-1:0] out_pixel
);

    import bicubic_pkg::*;

    bicubic_tap_if taps ();

    bicubic_tap_mult u_tap_mult (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .in_valid (in_valid),
        .phase    (phase_e'(phase)),
        .pixel0   (pixel0),
        .pixel1   (pixel1),
        .pixel2   (pixel2),
        .pixel3   (pixel3),
        .taps     (taps.source)
    );

    bicubic_tap_sum u_tap_sum (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .taps      (taps.sink),
        .out_valid (out_valid),
        .out_pixel (out_pixel)
    );

endmodule

// ==== src/bicubic_pkg.sv ====
package bicubic_pkg;

    // Multiplier opcode, one per weight constant
    typedef enum logic [2:0] {
        W_N21   = 3'd0,
        W_N135  = 3'd1,
        W_N147  = 3'd2,
        W_N225  = 3'd3,
        W_P235  = 3'd4,
        W_P873  = 3'd5,
        W_P1535 = 3'd6,
        W_P1981 = 3'd7
    } weight_code_e;

    typedef enum logic [1:0] {
        PHASE_0 = 2'd0,
        PHASE_1 = 2'd1,
        PHASE_2 = 2'd2,
        PHASE_3 = 2'd3
    } phase_e;

    typedef struct packed {
        weight_code_e tap0;
        weight_code_e tap1;
        weight_code_e tap2;
        weight_code_e tap3;
    } tap_codes_t;

    // Phases 2 and 3 mirror phases 1 and 0
    function automatic tap_codes_t phase_codes(phase_e phase);
        tap_codes_t codes;
        case (phase)
            PHASE_0: codes = '{W_N147, W_P1981, W_P235, W_N21};
            PHASE_1: codes = '{W_N225, W_P1535, W_P873, W_N135};
            PHASE_2: codes = '{W_N135, W_P873, W_P1535, W_N225};
            default: codes = '{W_N21, W_P235, W_P1981, W_N147};
        endcase
        return codes;
    endfunction

    function automatic logic signed [11:0] weight_value(weight_code_e code);
        logic signed [11:0] value;
        case (code)
            W_N21:   value = -12'sd21;
            W_N135:  value = -12'sd135;
            W_N147:  value = -12'sd147;
            W_N225:  value = -12'sd225;
            W_P235:  value = 12'sd235;
            W_P873:  value = 12'sd873;
            W_P1535: value = 12'sd1535;
            default: value = 12'sd1981;
        endcase
        return value;
    endfunction

endpackage

// ==== src/bicubic_tap_if.sv ====
`timescale 1ns/1ps
`include "bicubic_config.svh"

interface bicubic_tap_if;

    logic signed [`BICUBIC_PROD_W-1:0] product0;
    logic signed [`BICUBIC_PROD_W-1:0] product1;
    logic signed [`BICUBIC_PROD_W-1:0] product2;
    logic signed [`BICUBIC_PROD_W-1:0] product3;
    // One strobe per sample, only meaningful while en is high
    logic                              valid;

    modport source (
        output product0, product1, product2, product3, valid
    );

    modport sink (
        input product0, product1, product2, product3, valid
    );

endinterface

// ==== src/bicubic_tap_mult.sv ====
`timescale 1ns/1ps
`include "bicubic_config.svh"

module bicubic_tap_mult (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        en,
    input  logic                        in_valid,
    input  bicubic_pkg::phase_e         phase,
    input  logic [`BICUBIC_PIXEL_W-1:0] pixel0,
    input  logic [`BICUBIC_PIXEL_W-1:0] pixel1,
    input  logic [`BICUBIC_PIXEL_W-1:0] pixel2,
    input  logic [`BICUBIC_PIXEL_W-1:0] pixel3,
    bicubic_tap_if.source               taps
);

    import bicubic_pkg::*;

    localparam int STAGES = `BICUBIC_MULT_STAGES;

    tap_codes_t codes;

    assign codes = phase_codes(phase);

    bicubic_weight_mult u_mult0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .code    (codes.tap0),
        .pixel   (pixel0),
        .product (taps.product0)
    );

    bicubic_weight_mult u_mult1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .code    (codes.tap1),
        .pixel   (pixel1),
        .product (taps.product1)
    );

    bicubic_weight_mult u_mult2 (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .code    (codes.tap2),
        .pixel   (pixel2),
        .product (taps.product2)
    );

    bicubic_weight_mult u_mult3 (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .code    (codes.tap3),
        .pixel   (pixel3),
        .product (taps.product3)
    );

    // Valid follows the same number of enabled stages as the products
    generate
        if (STAGES == 0) begin : g_valid_comb
            assign taps.valid = in_valid;
        end else begin : g_valid_pipe
            logic [STAGES-1:0] valid_q;

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    valid_q <= '0;
                end else if (en) begin
                    valid_q[0] <= in_valid;
                    for (int i = 1; i < STAGES; i++) begin
                        valid_q[i] <= valid_q[i-1];
                    end
                end
            end

            assign taps.valid = valid_q[STAGES-1];
        end
    endgenerate

endmodule

// ==== src/bicubic_tap_sum.sv ====
`timescale 1ns/1ps
`include "bicubic_config.svh"

module bicubic_tap_sum (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        en,
    bicubic_tap_if.sink                 taps,
    output logic                        out_valid,
    output logic [`BICUBIC_PIXEL_W-1:0] out_pixel
);

    localparam int PIXEL_W   = `BICUBIC_PIXEL_W;
    localparam int SUM_W     = `BICUBIC_SUM_W;
    localparam int FRAC_BITS = `BICUBIC_FRAC_BITS;
    localparam int PIX_MAX   = (1 << PIXEL_W) - 1;

    logic signed [SUM_W-1:0] sum;
    logic signed [SUM_W-1:0] rounded;
    logic signed [SUM_W-1:0] scaled;
    logic [PIXEL_W-1:0]      clamped;

    // Products are signed, so they sign-extend to the sum width
    assign sum = taps.product0 + taps.product1 + taps.product2 + taps.product3;

    // Round half up before dropping the fraction
    assign rounded = sum + SUM_W'(1 << (FRAC_BITS - 1));
    assign scaled  = rounded >>> FRAC_BITS;

    always_comb begin
        if (scaled < 0) begin
            clamped = '0;
        end else if (scaled > PIX_MAX) begin
            clamped = '1;
        end else begin
            clamped = scaled[PIXEL_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_pixel <= '0;
        end else if (en) begin
            out_valid <= taps.valid;
            out_pixel <= clamped;
        end
    end

endmodule

// ==== src/bicubic_weight_mult.sv ====
`timescale 1ns/1ps
`include "bicubic_config.svh"

module bicubic_weight_mult (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              en,
    input  bicubic_pkg::weight_code_e         code,
    input  logic [`BICUBIC_PIXEL_W-1:0]       pixel,
    output logic signed [`BICUBIC_PROD_W-1:0] product
);

    import bicubic_pkg::*;

    localparam int PROD_W = `BICUBIC_PROD_W;
    localparam int STAGES = `BICUBIC_MULT_STAGES;

    logic signed [11:0]       weight;
    logic signed [PROD_W-1:0] product_comb;

    assign weight = weight_value(code);

    // Pixel is unsigned, so extend with a zero before the signed multiply
    assign product_comb = $signed({1'b0, pixel}) * weight;

    generate
        if (STAGES == 0) begin : g_comb
            assign product = product_comb;
        end else begin : g_pipe
            logic signed [PROD_W-1:0] pipe_q [STAGES];

            always_ff @(posedge clk) begin
                if (!rst_n) begin
                    for (int i = 0; i < STAGES; i++) begin
                        pipe_q[i] <= '0;
                    end
                end else if (en) begin
                    pipe_q[0] <= product_comb;
                    for (int i = 1; i < STAGES; i++) begin
                        pipe_q[i] <= pipe_q[i-1];
                    end
                end
            end

            assign product = pipe_q[STAGES-1];
        end
    endgenerate

endmodule
